// ==== hdl/cdc_lane_consts.svh ====
`ifndef CDC_LANE_CONSTS_SVH
`define CDC_LANE_CONSTS_SVH

// number of independent FIFO lanes behind the bridge.
`define CDC_LANES 4

// payload bits carried per word.
`define CDC_WIDTH 16

// words per lane; CDC_AW must stay at log2 of this.
`define CDC_DEPTH 8
`define CDC_AW    3

`endif

// ==== hdl/cdc_lane_pkg.sv ====
`include "cdc_lane_consts.svh"

package cdc_lane_pkg;

	// payload word as it sits in a lane RAM.
	typedef logic [`CDC_WIDTH-1:0] lane_data_t;

	typedef logic [$clog2(`CDC_LANES)-1:0] lane_id_t; // lane tag.

	typedef logic [`CDC_AW-1:0] lane_addr_t; // RAM address.

	// one extra bit over the address tells a full lane from an empty one.
	typedef logic [`CDC_AW:0] lane_ptr_t;

	typedef logic [`CDC_LANES-1:0] lane_mask_t; // one bit per lane.

	typedef logic [15:0] drop_cnt_t; // saturates at all ones.

	// the tagged word serves both the write input and the read output.
	typedef struct packed {
		lane_id_t   lane;
		lane_data_t data;
	} bridge_word_t;

endpackage

// ==== hdl/lane_ram.sv ====
`timescale 1ns/1ps
`include "cdc_lane_consts.svh"

module lane_ram import cdc_lane_pkg::*; (
	input  logic       wclk,
	input  logic       wenc,
	input  lane_addr_t waddr,
	input  lane_data_t wdata,
	input  logic       rclk,
	input  logic       renc,
	input  lane_addr_t raddr,
	output lane_data_t rdata
);

	lane_data_t mem [`CDC_DEPTH];

	// write port lives entirely in the wclk domain.
	always_ff @(posedge wclk) begin
		if (wenc)
			mem[waddr] <= wdata;
	end

	always_ff @(posedge rclk) begin
		if (renc)
			rdata <= mem[raddr]; // holds its value between pops.
	end

endmodule

// ==== hdl/async_lane_fifo.sv ====
`timescale 1ns/1ps
`include "cdc_lane_consts.svh"

module async_lane_fifo import cdc_lane_pkg::*; (
	input  logic       wclk,
	input  logic       rclk,
	input  logic       rrstn,
	input  logic       winc,
	input  logic       rinc,
	input  lane_data_t wdata,
	output logic       wfull,
	output logic       rempty,
	output lane_data_t rdata
);

	lane_ptr_t  wbin;
	lane_ptr_t  wbin_next;
	lane_ptr_t  wgray;
	lane_ptr_t  rbin;
	lane_ptr_t  rbin_next;
	lane_ptr_t  rgray;
	lane_ptr_t  wgray_meta;
	lane_ptr_t  wgray_sync;
	lane_ptr_t  rgray_meta;
	lane_ptr_t  rgray_sync;
	lane_ptr_t  rgray_full;
	lane_addr_t waddr;
	lane_addr_t raddr;

	function automatic lane_ptr_t to_gray(input lane_ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// the steer block and the arbiter already checked full and empty.
	assign wbin_next = wbin + lane_ptr_t'(winc);
	assign rbin_next = rbin + lane_ptr_t'(rinc);

	// the gray register is loaded from the next binary value, so it always
	// matches the binary pointer and the flags need no extra cycle.
	always_ff @(posedge wclk or negedge rrstn) begin
		if (!rrstn) begin
			wbin  <= '0;
			wgray <= '0;
		end else begin
			wbin  <= wbin_next;
			wgray <= to_gray(wbin_next);
		end
	end

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rbin  <= '0;
			rgray <= '0;
		end else begin
			rbin  <= rbin_next;
			rgray <= to_gray(rbin_next);
		end
	end

	// read pointer into the write domain.
	always_ff @(posedge wclk or negedge rrstn) begin
		if (!rrstn) begin
			rgray_meta <= '0;
			rgray_sync <= '0;
		end else begin
			rgray_meta <= rgray;
			rgray_sync <= rgray_meta;
		end
	end

	// write pointer into the read domain.
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			wgray_meta <= '0;
			wgray_sync <= '0;
		end else begin
			wgray_meta <= wgray;
			wgray_sync <= wgray_meta;
		end
	end

	// a full lane has wrapped once, which in gray code flips the top two bits.
	assign rgray_full = {~rgray_sync[`CDC_AW:`CDC_AW-1], rgray_sync[`CDC_AW-2:0]};
	assign wfull      = (wgray == rgray_full);
	assign rempty     = (rgray == wgray_sync);

	assign waddr = wbin[`CDC_AW-1:0];
	assign raddr = rbin[`CDC_AW-1:0];

	lane_ram u_ram (
		.wclk  (wclk),
		.wenc  (winc),
		.waddr (waddr),
		.wdata (wdata),
		.rclk  (rclk),
		.renc  (rinc),
		.raddr (raddr),
		.rdata (rdata)
	);

endmodule

// ==== hdl/lane_steer.sv ====
`timescale 1ns/1ps

module lane_steer import cdc_lane_pkg::*; (
	input  logic         wclk,
	input  logic         rrstn,
	input  logic         wr_valid,
	input  bridge_word_t wr_word,
	input  lane_mask_t   lane_full,
	output lane_mask_t   winc,
	output drop_cnt_t    drop_count
);

	logic target_full;
	logic reject;

	assign target_full = lane_full[wr_word.lane];

	// a strobe aimed at a full lane is lost here and only counted.
	assign reject = wr_valid && target_full;

	always_comb begin
		winc = '0;
		if (wr_valid && !target_full)
			winc[wr_word.lane] = 1'b1; // exactly one lane takes the word.
	end

	always_ff @(posedge wclk or negedge rrstn) begin
		if (!rrstn) begin
			drop_count <= '0;
		end else if (reject && (drop_count != '1)) begin
			drop_count <= drop_count + 1'b1; // sticks at the top value.
		end
	end

endmodule

// ==== hdl/lane_arbiter.sv ====
`timescale 1ns/1ps
`include "cdc_lane_consts.svh"

module lane_arbiter import cdc_lane_pkg::*; (
	input  logic         rclk,
	input  logic         rrstn,
	input  logic         drain,
	input  lane_mask_t   lane_empty,
	input  lane_data_t   lane_rdata [`CDC_LANES],
	output lane_mask_t   rinc,
	output logic         rd_valid,
	output bridge_word_t rd_word
);

	lane_id_t last_grant;
	lane_id_t cand;
	lane_id_t grant_id;
	logic     grant_hit;
	logic     pop;
	lane_id_t stage_lane;
	logic     stage_pend;

	// search starts one past the last grant and wraps, so the lane served
	// last has the lowest priority next time.
	always_comb begin
		grant_hit = 1'b0;
		grant_id  = last_grant;
		cand      = last_grant;
		for (int i = 1; i <= `CDC_LANES; i++) begin
			cand = lane_id_t'(last_grant + i);
			if (!grant_hit && !lane_empty[cand]) begin
				grant_hit = 1'b1;
				grant_id  = cand;
			end
		end
	end

	assign pop = drain && grant_hit;

	always_comb begin
		rinc = '0;
		if (pop)
			rinc[grant_id] = 1'b1;
	end

	// stage 1 remembers which lane RAM was read at the pop edge.
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			last_grant <= lane_id_t'(`CDC_LANES - 1);
			stage_lane <= '0;
			stage_pend <= 1'b0;
			rd_valid   <= 1'b0;
		end else begin
			stage_pend <= pop;
			rd_valid   <= stage_pend; // one-cycle pulse per popped word.
			if (pop) begin
				last_grant <= grant_id;
				stage_lane <= grant_id;
			end
		end
	end

	// stage 2 picks up the registered RAM output one edge after the pop.
	always_ff @(posedge rclk) begin
		if (stage_pend) begin
			rd_word.lane <= stage_lane;
			rd_word.data <= lane_rdata[stage_lane];
		end
	end

endmodule

// ==== hdl/cdc_lane_bridge.sv ====
`timescale 1ns/1ps
`include "cdc_lane_consts.svh"

module cdc_lane_bridge import cdc_lane_pkg::*; (
	input  logic         wclk,
	input  logic         rclk,
	input  logic         rrstn,
	input  logic         wr_valid,
	input  bridge_word_t wr_word,
	input  logic         drain,
	output lane_mask_t   lane_full,
	output lane_mask_t   lane_empty,
	output drop_cnt_t    drop_count,
	output logic         rd_valid,
	output bridge_word_t rd_word
);

	lane_mask_t winc;
	lane_mask_t rinc;
	lane_data_t lane_rdata [`CDC_LANES];

	// the write side runs on wclk.
	lane_steer u_steer (
		.wclk       (wclk),
		.rrstn      (rrstn),
		.wr_valid   (wr_valid),
		.wr_word    (wr_word),
		.lane_full  (lane_full),
		.winc       (winc),
		.drop_count (drop_count)
	);

	// every lane sees the same data bus; only its winc bit stores it.
	for (genvar g = 0; g < `CDC_LANES; g++) begin : g_lane
		async_lane_fifo u_fifo (
			.wclk   (wclk),
			.rclk   (rclk),
			.rrstn  (rrstn),
			.winc   (winc[g]),
			.rinc   (rinc[g]),
			.wdata  (wr_word.data),
			.wfull  (lane_full[g]),
			.rempty (lane_empty[g]),
			.rdata  (lane_rdata[g])
		);
	end

	// the read side runs on rclk.
	lane_arbiter u_arbiter (
		.rclk       (rclk),
		.rrstn      (rrstn),
		.drain      (drain),
		.lane_empty (lane_empty),
		.lane_rdata (lane_rdata),
		.rinc       (rinc),
		.rd_valid   (rd_valid),
		.rd_word    (rd_word)
	);

endmodule

// ==== sim/cdc_lane_bridge_checker.sv ====
`timescale 1ns/1ps

module cdc_lane_bridge_checker import cdc_lane_pkg::*; (
	input logic       wclk,
	input logic       rclk,
	input logic       rrstn,
	input lane_mask_t winc,
	input lane_mask_t rinc,
	input lane_mask_t lane_full,
	input logic       rd_valid
);

	// the arbiter grants one lane per read cycle at most.
	a_rinc_onehot: assert property (@(posedge rclk) disable iff (!rrstn) $onehot0(rinc))
		else $error("rinc has more than one lane bit set");

	// a pop sampled at edge t is seen as rd_valid at edge t+2.
	a_pop_to_valid: assert property (@(posedge rclk) disable iff (!rrstn) (|rinc) |-> ##2 rd_valid)
		else $error("rd_valid missing two read clock edges after a pop");
	a_valid_from_pop: assert property (@(posedge rclk) disable iff (!rrstn)
		rd_valid |-> $past(|rinc, 2))
		else $error("rd_valid without a pop two read clock edges before");

	a_reset_quiet: assert property (@(posedge rclk) !rrstn |-> !rd_valid)
		else $error("rd_valid high while reset is asserted");

	// writes are gated by the target lane's full flag in the steer block.
	a_no_full_write: assert property (@(posedge wclk) disable iff (!rrstn)
		(winc & lane_full) == '0)
		else $error("winc targets a lane whose full flag is high");

endmodule

bind cdc_lane_bridge cdc_lane_bridge_checker u_checker (
	.wclk      (wclk),
	.rclk      (rclk),
	.rrstn     (rrstn),
	.winc      (winc),
	.rinc      (rinc),
	.lane_full (lane_full),
	.rd_valid  (rd_valid)
);

// ==== sim/cdc_lane_bridge_tb.sv ====
`timescale 1ns/1ps
`include "cdc_lane_consts.svh"

module cdc_lane_bridge_tb import cdc_lane_pkg::*; ();

	typedef struct {
		string      name;
		lane_id_t   lane;
		lane_data_t data;
		logic       drain;
		logic       exp_drop;
	} stim_row_t;

	logic         wclk = 1'b0;
	logic         rclk = 1'b0;
	logic         rrstn;
	logic         wr_valid;
	bridge_word_t wr_word;
	logic         drain;
	lane_mask_t   lane_full;
	lane_mask_t   lane_empty;
	drop_cnt_t    drop_count;
	logic         rd_valid;
	bridge_word_t rd_word;

	stim_row_t    table_q[$];
	lane_data_t   model_q[`CDC_LANES][$]; // one queue per lane.
	lane_id_t     model_last;
	drop_cnt_t    model_drops;
	bridge_word_t got_q[$];
	int           err_count;
	int           test_count;
	int           test_fails;
	int           test_start;

	always #4 rclk = ~rclk;
	always #5.5 wclk = ~wclk;

	cdc_lane_bridge uut (
		.wclk       (wclk),
		.rclk       (rclk),
		.rrstn      (rrstn),
		.wr_valid   (wr_valid),
		.wr_word    (wr_word),
		.drain      (drain),
		.lane_full  (lane_full),
		.lane_empty (lane_empty),
		.drop_count (drop_count),
		.rd_valid   (rd_valid),
		.rd_word    (rd_word)
	);

	// rd_word and rd_valid change on the rising edge, so the falling edge sees them settled.
	always @(negedge rclk) begin
		if (rrstn && rd_valid)
			got_q.push_back(rd_word);
	end

	task automatic check_word(input string name, input bridge_word_t exp, input bridge_word_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected lane %0d data %h, actual lane %0d data %h",
				name, exp.lane, exp.data, act.lane, act.data);
			err_count++;
		end
	endtask

	task automatic check_drops(input string name, input drop_cnt_t exp, input drop_cnt_t act);
		if (exp !== act) begin
			$display("Mismatch %s: drop_count expected %0d, actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_mask(input string name, input string what, input lane_mask_t exp,
		input lane_mask_t act);
		if (exp !== act) begin
			$display("Mismatch %s: %s expected %b, actual %b", name, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
		input logic act);
		if (exp !== act) begin
			$display("Mismatch %s: %s expected %b, actual %b", name, what, exp, act);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count != test_start)
			test_fails++;
		$display("test %s: %s", name, (err_count == test_start) ? "ok" : "FAILED");
		test_start = err_count;
	endtask

	function automatic int model_words();
		int n;
		n = 0;
		for (int l = 0; l < `CDC_LANES; l++)
			n += model_q[l].size();
		return n;
	endfunction

	// the next grant is the first non-empty lane after the last one, with wrap.
	function automatic lane_id_t next_lane();
		lane_id_t l;
		for (int i = 1; i <= `CDC_LANES; i++) begin
			l = lane_id_t'(model_last + i);
			if (model_q[l].size() != 0)
				return l;
		end
		return model_last;
	endfunction

	task automatic set_drain(input logic level);
		@(posedge rclk);
		drain <= level;
	endtask

	task automatic apply_rows(input int first, input int last);
		stim_row_t  row;
		lane_mask_t exp_full;
		for (int i = first; i <= last; i++) begin
			row = table_q[i];
			@(posedge wclk);
			wr_valid <= 1'b1;
			wr_word  <= '{lane: row.lane, data: row.data};
			drain    <= row.drain;
			@(posedge wclk);
			wr_valid <= 1'b0;
			if (row.exp_drop)
				model_drops++;
			else
				model_q[row.lane].push_back(row.data);
			@(negedge wclk);
			if (!row.drain) begin // without reads the full flag follows the count exactly.
				for (int l = 0; l < `CDC_LANES; l++)
					exp_full[l] = (model_q[l].size() == `CDC_DEPTH);
				check_mask(row.name, "lane_full", exp_full, lane_full);
			end
		end
	endtask

	task automatic wait_flags(input string name, input lane_mask_t exp_empty,
		input lane_mask_t exp_full);
		int n;
		for (n = 0; n < 400; n++) begin
			@(negedge rclk);
			if (lane_empty === exp_empty && lane_full === exp_full)
				break;
		end
		if (n == 400) begin
			$display("%s: lane flags did not settle within 400 read clock cycles", name);
			err_count++;
			check_mask(name, "lane_empty", exp_empty, lane_empty);
			check_mask(name, "lane_full", exp_full, lane_full);
		end
	endtask

	task automatic check_next_word(input string name, input bit in_order, output bit ok);
		bridge_word_t act;
		bridge_word_t exp;
		int           n;
		ok = 1'b0;
		for (n = 0; n < 200 && got_q.size() == 0; n++)
			@(negedge rclk);
		if (got_q.size() == 0) begin
			$display("%s: no word came out within 200 read clock cycles", name);
			err_count++;
			return;
		end
		act = got_q.pop_front();
		exp.lane = in_order ? next_lane() : act.lane;
		if (model_q[exp.lane].size() == 0) begin
			$display("%s: a word came out of lane %0d, which holds no words", name, exp.lane);
			err_count++;
			return;
		end
		exp.data = model_q[exp.lane].pop_front();
		model_last = act.lane;
		check_word(name, exp, act);
		ok = 1'b1;
	endtask

	task automatic drain_model(input string name, input bit in_order);
		bit ok;
		while (model_words() != 0) begin
			check_next_word(name, in_order, ok);
			if (!ok) begin
				for (int l = 0; l < `CDC_LANES; l++)
					model_q[l].delete();
			end
		end
	endtask

	task automatic check_quiet(input string name);
		repeat (20) @(negedge rclk);
		if (got_q.size() != 0) begin
			$display("%s: %0d extra words came out", name, got_q.size());
			err_count++;
			got_q.delete();
		end
	endtask

	initial begin
		rrstn       = 1'b0;
		wr_valid    = 1'b0;
		wr_word     = '0;
		drain       = 1'b0;
		err_count   = 0;
		test_count  = 0;
		test_fails  = 0;
		test_start  = 0;
		model_drops = '0;
		model_last  = lane_id_t'(`CDC_LANES - 1);
		void'($urandom(92));

		// ten words go to lane 0 and the last two find it full.
		for (int i = 0; i < 10; i++)
			table_q.push_back('{"fill_drop", lane_id_t'(0), lane_data_t'(16'h1000 + i),
				1'b0, logic'(i >= `CDC_DEPTH)});
		for (int i = 0; i < 24; i++)
			table_q.push_back('{"mixed_lanes", lane_id_t'($urandom), lane_data_t'($urandom),
				1'b1, 1'b0});
		for (int i = 0; i < 12; i++)
			table_q.push_back('{"round_robin", lane_id_t'(i % `CDC_LANES),
				lane_data_t'(16'h3000 + i), 1'b0, 1'b0});

		repeat (10) @(posedge rclk);
		#2;
		rrstn = 1'b1; // released between the rising and falling edges of rclk.

		@(negedge rclk);
		check_mask("reset", "lane_empty", '1, lane_empty);
		check_mask("reset", "lane_full", '0, lane_full);
		check_drops("reset", '0, drop_count);
		check_flag("reset", "rd_valid", 1'b0, rd_valid);
		finish_test("reset");

		apply_rows(0, 9);
		check_drops("fill_drop", model_drops, drop_count);
		finish_test("fill_drop");

		set_drain(1'b1);
		drain_model("drain_order", 1'b1);
		check_quiet("drain_order");
		wait_flags("drain_order", '1, '0);
		finish_test("drain_order");

		apply_rows(10, 33);
		drain_model("mixed_lanes", 1'b0);
		check_quiet("mixed_lanes");
		wait_flags("mixed_lanes", '1, '0);
		check_drops("mixed_lanes", model_drops, drop_count);
		finish_test("mixed_lanes");

		set_drain(1'b0);
		repeat (20) @(negedge rclk);
		apply_rows(34, 45);
		wait_flags("round_robin", '0, '0);
		set_drain(1'b1);
		drain_model("round_robin", 1'b1);
		check_quiet("round_robin");
		finish_test("round_robin");

		$display("tests %0d, failed %0d, errors %0d", test_count, test_fails, err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== cdc_lane_bridge.f ====
+incdir+hdl
hdl/cdc_lane_pkg.sv
hdl/lane_ram.sv
hdl/async_lane_fifo.sv
hdl/lane_steer.sv
hdl/lane_arbiter.sv
hdl/cdc_lane_bridge.sv
sim/cdc_lane_bridge_checker.sv
sim/cdc_lane_bridge_tb.sv
